// ==== flist.f ====
rtl/riscvPkg.sv
rtl/busPkg.sv
rtl/controlUnit.sv
rtl/aluUnit.sv
rtl/registerFile.sv
rtl/immediateGen.sv
rtl/memoryArray.sv
rtl/apbPort.sv
rtl/coreTop.sv
bench/coreTop_props.sv
bench/coreTb.sv

// ==== bench/coreTb.sv ====
`timescale 1ns/100ps

module coreTb;

    localparam int numProgs   = 6;
    localparam int progLen    = 40;             // Words per program, self loop included
    localparam int maxSteps   = progLen + 8;
    localparam int apbOps     = 547 + numProgs * (progLen + 299 + maxSteps / 2);
    localparam int cycleLimit = 2 * (numProgs * maxSteps + 2 * apbOps) + 10;
    localparam logic [11:0] stepAddr = busPkg::ctrlBase + 12'(busPkg::stepOff);
    localparam logic [11:0] pcAddr   = busPkg::ctrlBase + 12'(busPkg::pcOff);

    logic           clk = 1'b0;
    logic           rst;
    busPkg::apbReqT req;
    busPkg::apbRspT rsp;
    int             cycles = 0;

    logic [31:0] mReg  [32];   // Reference model state
    logic [7:0]  mDmem [256];
    logic [31:0] mImem [256];
    logic [31:0] mPc;

    coreTop uut (.clk(clk), .rst(rst), .req(req), .rsp(rsp));

    always #4 clk = ~clk;  // 8 ns period

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycleLimit) begin
            $display("Timeout: run went past %0d cycles without finishing", cycleLimit);
            $display("Result: FAILED");
            $fatal(1, "Run stopped at the cycle limit");
        end
    end

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    // One APB transfer, entered and left 1 ns after a rising edge
    task automatic transfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        req.psel    = 1'b1;  // Setup phase
        req.penable = 1'b0;
        req.pwrite  = wr;
        req.paddr   = addr;
        req.pwdata  = wdata;
        @(posedge clk);
        #1;
        req.penable = 1'b1;  // Access phase
        @(negedge clk);
        checkValue($sformatf("pready at 0x%03h", addr), 32'd1, {31'b0, rsp.pready});
        rdata = rsp.prdata;
        err   = rsp.pslverr;
        @(posedge clk);
        #1;
        req.psel    = 1'b0;
        req.penable = 1'b0;
    endtask

    task automatic writeWord(input logic [11:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        logic        err;
        transfer(1'b1, addr, data, unused, err);
        checkValue($sformatf("pslverr on write 0x%03h", addr), 32'd0, {31'b0, err});
    endtask

    task automatic readWord(input logic [11:0] addr, output logic [31:0] data);
        logic err;
        transfer(1'b0, addr, 32'd0, data, err);
        checkValue($sformatf("pslverr on read 0x%03h", addr), 32'd0, {31'b0, err});
    endtask

    function automatic logic [31:0] rType(input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [4:0] rs2);
        return {7'b0, rs2, rs1, f3, rd, riscvPkg::opReg};
    endfunction

    function automatic logic [31:0] iType(input logic [6:0] op, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] sType(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b000, imm[4:0], riscvPkg::opStore};  // sb
    endfunction

    function automatic logic [31:0] bType(input logic [12:0] off, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {off[12], off[10:5], rs2, rs1, 3'b001, off[4:1], off[11], riscvPkg::opBranch};
    endfunction

    function automatic logic [31:0] uType(input logic [6:0] op, input logic [4:0] rd,
                                          input logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] jType(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, riscvPkg::opJal};
    endfunction

    function automatic void setReg(input logic [4:0] rd, input logic [31:0] value);
        if (rd != 5'd0) begin
            mReg[rd] = value;  // x0 stays zero
        end
    endfunction

    // Random program, only forward control flow, ends in jal x0, 0
    task automatic buildProgram();
        int          kind, k, lastIdx;
        logic [4:0]  rd, rs1, rs2;
        logic [31:0] r;
        lastIdx = progLen - 1;
        for (int i = 0; i < 8; i += 2) begin
            rd = 5'($urandom_range(1, 31));  // Seed registers with random operands
            r  = $urandom();
            mImem[i]     = uType(riscvPkg::opLui, rd, r[31:12]);
            mImem[i + 1] = iType(riscvPkg::opImm, 3'd0, rd, rd, r[11:0]);
        end
        for (int i = 8; i < lastIdx; i++) begin
            kind = $urandom_range(0, 11);
            rd   = ($urandom_range(0, 7) == 0) ? 5'd0 : 5'($urandom_range(1, 31));
            rs1  = 5'($urandom_range(0, 31));
            rs2  = ($urandom_range(0, 3) == 0) ? rs1 : 5'($urandom_range(0, 31));  // Not taken
            r    = $urandom();
            k    = $urandom_range(1, (lastIdx - i < 4) ? lastIdx - i : 4);  // Words ahead
            case (kind)
                0:  mImem[i] = rType(3'd0, rd, rs1, rs2);  // add
                1:  mImem[i] = iType(riscvPkg::opImm, 3'd0, rd, rs1, r[11:0]);
                2:  mImem[i] = rType(3'd1, rd, rs1, rs2);  // sll
                3:  mImem[i] = iType(riscvPkg::opImm, 3'd1, rd, rs1, {7'b0, r[4:0]});
                4:  mImem[i] = iType(riscvPkg::opLoad, 3'd4, rd, rs1, r[11:0]);  // lbu
                5:  mImem[i] = sType(r[11:0], rs2, rs1);
                6:  mImem[i] = bType(13'(4 * k), rs1, rs2);
                7:  mImem[i] = jType(21'(4 * k), rd);
                8:  mImem[i] = iType(riscvPkg::opJalr, 3'd0, rd, 5'd0,
                                     12'(4 * (i + k)) | {11'b0, r[0]});  // Odd target too
                9:  mImem[i] = uType(riscvPkg::opLui, rd, r[31:12]);
                10: mImem[i] = uType(riscvPkg::opAuipc, rd, r[31:12]);
                default: mImem[i] = {r[31:7], 7'b0001111};  // fence, runs as nop
            endcase
        end
        mImem[lastIdx] = jType(21'd0, 5'd0);
    endtask

    // ISA reference model, one instruction
    task automatic modelStep();
        logic [31:0] ins, a, b, immI, immS, immB, immU, immJ, next;
        logic [4:0]  rd;
        logic [2:0]  f3;
        ins  = mImem[mPc[9:2]];
        rd   = ins[11:7];
        f3   = ins[14:12];
        a    = mReg[ins[19:15]];
        b    = mReg[ins[24:20]];
        immI = {{20{ins[31]}}, ins[31:20]};
        immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        immB = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        immU = {ins[31:12], 12'b0};
        immJ = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        next = mPc + 32'd4;
        case (ins[6:0])
            riscvPkg::opReg: begin
                if (f3 == 3'd0) setReg(rd, a + b);
                else if (f3 == 3'd1) setReg(rd, a << b[4:0]);
            end
            riscvPkg::opImm: begin
                if (f3 == 3'd0) setReg(rd, a + immI);
                else if (f3 == 3'd1) setReg(rd, a << immI[4:0]);
            end
            riscvPkg::opLoad: if (f3 == 3'd4) setReg(rd, {24'b0, mDmem[8'(a + immI)]});
            riscvPkg::opStore: if (f3 == 3'd0) mDmem[8'(a + immS)] = b[7:0];
            riscvPkg::opBranch: if (f3 == 3'd1 && a != b) next = mPc + immB;
            riscvPkg::opLui: setReg(rd, immU);
            riscvPkg::opAuipc: setReg(rd, mPc + immU);
            riscvPkg::opJal: begin
                setReg(rd, mPc + 32'd4);
                next = mPc + immJ;
            end
            riscvPkg::opJalr: begin
                if (f3 == 3'd0) begin
                    next = (a + immI) & ~32'd1;  // Target taken before the link write
                    setReg(rd, mPc + 32'd4);
                end
            end
            default: ;  // Anything else is a nop
        endcase
        mPc = next;
    endtask

    initial begin
        logic [31:0] data;
        logic        err;
        int          steps;
        string       testName;
        void'($urandom(32'h77bb_c7d4));  // Single seeding of the run
        req = '0;
        rst = 1'b1;
        mPc = 32'd0;
        for (int i = 0; i < 32; i++) mReg[i] = 32'd0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        testName = "memRw";
        for (int i = 0; i < 256; i++) begin
            data     = $urandom();
            mDmem[i] = data[7:0];  // Only the low byte is kept
            writeWord(busPkg::dmemBase + 12'(4 * i), data);
        end
        for (int i = 0; i < 256; i++) begin
            readWord(busPkg::dmemBase + 12'(4 * i), data);
            checkValue($sformatf("%s dmem[%0d]", testName, i), {24'b0, mDmem[i]}, data);
        end
        for (int i = 200; i < 216; i++) begin
            mImem[i] = $urandom();
            writeWord(busPkg::imemBase + 12'(4 * i), mImem[i]);
        end
        for (int i = 200; i < 216; i++) begin
            readWord(busPkg::imemBase + 12'(4 * i), data);
            checkValue($sformatf("%s imem[%0d]", testName, i), mImem[i], data);
        end
        transfer(1'b0, 12'h002, 32'd0, data, err);  // Misaligned
        checkValue("unmapped 0x002", 32'd1, {31'b0, err});
        transfer(1'b1, 12'h880, 32'd5, data, err);  // Past x31
        checkValue("unmapped 0x880", 32'd1, {31'b0, err});
        transfer(1'b0, 12'hC08, 32'd0, data, err);
        checkValue("unmapped 0xC08", 32'd1, {31'b0, err});

        for (int p = 0; p < numProgs; p++) begin
            testName = $sformatf("prog%0d", p);
            buildProgram();
            for (int i = 0; i < progLen; i++) begin
                writeWord(busPkg::imemBase + 12'(4 * i), mImem[i]);
            end
            writeWord(pcAddr, 32'd0);
            mPc   = 32'd0;
            steps = $urandom_range(24, maxSteps);
            writeWord(stepAddr, 32'(steps));
            // Core is running, every one of these must be refused
            transfer(1'b1, busPkg::imemBase, $urandom(), data, err);
            checkValue({testName, " busy imem write"}, 32'd1, {31'b0, err});
            transfer(1'b1, busPkg::dmemBase + 12'(4 * $urandom_range(0, 255)), $urandom(),
                     data, err);
            checkValue({testName, " busy dmem write"}, 32'd1, {31'b0, err});
            transfer(1'b0, busPkg::regBase + 12'(4 * $urandom_range(0, 31)), 32'd0, data, err);
            checkValue({testName, " busy reg read"}, 32'd1, {31'b0, err});
            transfer(1'b1, pcAddr, $urandom(), data, err);
            checkValue({testName, " busy pc write"}, 32'd1, {31'b0, err});
            transfer(1'b0, pcAddr, 32'd0, data, err);
            checkValue({testName, " busy pc read"}, 32'd1, {31'b0, err});
            data = 32'hFFFF_FFFF;
            while (data != 32'd0) begin
                readWord(stepAddr, data);  // Remaining budget, zero when halted
            end
            repeat (steps) modelStep();
            readWord(pcAddr, data);
            checkValue({testName, " pc"}, mPc, data);
            readWord(busPkg::imemBase, data);  // Refused write left word 0 alone
            checkValue({testName, " imem[0]"}, mImem[0], data);
            for (int r = 0; r < 32; r++) begin
                readWord(busPkg::regBase + 12'(4 * r), data);
                checkValue($sformatf("%s x%0d", testName, r), mReg[r], data);
            end
            for (int i = 0; i < 256; i++) begin
                readWord(busPkg::dmemBase + 12'(4 * i), data);
                checkValue($sformatf("%s dmem[%0d]", testName, i), {24'b0, mDmem[i]}, data);
            end
        end

        if (uut.uProps.assertFails != 0) begin
            $display("%0d assertion failures were seen during the run", uut.uProps.assertFails);
            $display("Result: FAILED");
            $fatal(1, "Assertion failures");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

// ==== bench/coreTop_props.sv ====
`timescale 1ns/100ps

module coreTopProps (
    input logic           clk,
    input logic           rst,
    input busPkg::apbReqT req,
    input busPkg::apbRspT rsp,
    input logic           busy
);

    int assertFails = 0;  // Read by the testbench at the end

    penableAfterSetup: assert property (@(posedge clk) disable iff (rst)
        req.penable |-> req.psel && $past(req.psel && !req.penable))
        else begin
            $error("penable raised without a setup cycle before it");
            assertFails++;
        end

    readyInAccess: assert property (@(posedge clk) disable iff (rst)
        (req.psel && req.penable) |-> rsp.pready)
        else begin
            $error("pready low in an access cycle");
            assertFails++;
        end

    // Accepted read of x0 through the register window
    x0ReadsZero: assert property (@(posedge clk) disable iff (rst)
        (req.psel && req.penable && !req.pwrite && req.paddr == busPkg::regBase
         && !rsp.pslverr) |-> (rsp.prdata == '0))
        else begin
            $error("x0 read nonzero on the host port");
            assertFails++;
        end

    // Host data memory writes refused while running
    noHostStore: assert property (@(posedge clk) disable iff (rst)
        (busy && req.psel && req.penable && req.pwrite
         && req.paddr[11:10] == busPkg::dmemBase[11:10]) |-> rsp.pslverr)
        else begin
            $error("data memory write by the host accepted while busy");
            assertFails++;
        end

endmodule

bind coreTop coreTopProps uProps (
    .clk(clk), .rst(rst), .req(req), .rsp(rsp), .busy(busy)
);

// ==== rtl/coreTop.sv ====
`timescale 1ns/100ps

module coreTop (
    input  logic           clk,
    input  logic           rst,
    input  busPkg::apbReqT req,
    output busPkg::apbRspT rsp
);

    riscvPkg::ctrlWordT            ctrl;
    logic [riscvPkg::xlen-1:0]     instr, pc, pcPlus4;
    logic [riscvPkg::xlen-1:0]     aluResult, immValue;
    logic [riscvPkg::xlen-1:0]     rdata1, rdata2, regData;
    logic                          aluFlag, busy;
    logic                          stepLoad, pcLoad;
    logic [15:0]                   stepsLeft, stepValue;
    logic [riscvPkg::xlen-1:0]     pcValue;
    logic [7:0]                    dmemByte, hostDmemAddr;
    logic [riscvPkg::regAddrW-1:0] hostRegIdx;
    busPkg::memReqT                imemReq, dmemReq;

    controlUnit uCtrl (
        .clk(clk), .rst(rst), .instr(instr), .aluFlag(aluFlag),
        .aluResult(aluResult), .immValue(immValue),
        .stepLoad(stepLoad), .stepValue(stepValue), .pcLoad(pcLoad), .pcValue(pcValue),
        .ctrl(ctrl), .pc(pc), .pcPlus4(pcPlus4), .busy(busy), .stepsLeft(stepsLeft)
    );

    memoryArray #(.Payload(logic [riscvPkg::xlen-1:0]), .depth(riscvPkg::imemDepth)) uImem (
        .clk(clk), .wreq(imemReq),
        .raddr(busy ? pc[9:2] : imemReq.addr),  // Host reads while halted
        .rdata(instr)
    );

    memoryArray #(.Payload(logic [7:0]), .depth(riscvPkg::dmemDepth)) uDmem (
        .clk(clk), .wreq(dmemReq),
        .raddr(busy ? aluResult[7:0] : hostDmemAddr),
        .rdata(dmemByte)
    );

    immediateGen uImm (.instr(instr), .immSel(ctrl.immSel), .immValue(immValue));

    aluUnit uAlu (
        .opA(ctrl.aluSrcPc ? pc : rdata1),         // auipc uses the PC
        .opB(ctrl.aluSrcImm ? immValue : rdata2),
        .aluOp(ctrl.aluOp), .result(aluResult), .aluFlag(aluFlag)
    );

    registerFile uRegs (
        .clk(clk), .rst(rst), .we(ctrl.regWrite),
        .rs1(instr[19:15]), .rs2(instr[24:20]), .rd(instr[11:7]), .hostIdx(hostRegIdx),
        .wdata((ctrl.resultSel == riscvPkg::resPcPlus4) ? pcPlus4 :
               (ctrl.resultSel == riscvPkg::resMem) ? {24'b0, dmemByte} : aluResult),  // lbu
        .rdata1(rdata1), .rdata2(rdata2), .hostData(regData)
    );

    apbPort uApb (
        .clk(clk), .rst(rst), .req(req), .busy(busy),
        .stepsLeft(stepsLeft), .pc(pc), .regData(regData),
        .dmemData({24'b0, dmemByte}), .imemData(instr),
        .coreStore(busPkg::memReqT'{we: ctrl.memWrite, addr: aluResult[7:0],
                                    wdata: {24'b0, rdata2[7:0]}}),  // sb low byte
        .rsp(rsp), .imemReq(imemReq), .dmemReq(dmemReq),
        .hostRegIdx(hostRegIdx), .hostDmemAddr(hostDmemAddr),
        .stepLoad(stepLoad), .stepValue(stepValue), .pcLoad(pcLoad), .pcValue(pcValue)
    );

endmodule

// ==== rtl/apbPort.sv ====
`timescale 1ns/100ps

module apbPort (
    input  logic                          clk,
    input  logic                          rst,
    input  busPkg::apbReqT                req,
    input  logic                          busy,
    input  logic [15:0]                   stepsLeft,
    input  logic [riscvPkg::xlen-1:0]     pc,
    input  logic [riscvPkg::xlen-1:0]     regData,
    input  logic [riscvPkg::xlen-1:0]     dmemData,   // Zero-extended byte
    input  logic [riscvPkg::xlen-1:0]     imemData,
    input  busPkg::memReqT                coreStore,  // sb from the core
    output busPkg::apbRspT                rsp,
    output busPkg::memReqT                imemReq,
    output busPkg::memReqT                dmemReq,
    output logic [riscvPkg::regAddrW-1:0] hostRegIdx,
    output logic [7:0]                    hostDmemAddr,
    output logic                          stepLoad,
    output logic [15:0]                   stepValue,
    output logic                          pcLoad,
    output logic [riscvPkg::xlen-1:0]     pcValue
);

    logic                      setupSeen;  // Previous cycle was APB setup
    logic                      access;
    logic                      aligned;
    logic                      isImem, isDmem, isReg, isStep, isPc;
    logic                      err, wrOk;
    logic [riscvPkg::xlen-1:0] rdMux;

    always_ff @(posedge clk) begin
        if (rst) begin
            setupSeen <= 1'b0;
        end else begin
            setupSeen <= req.psel & ~req.penable;
        end
    end

    always_comb begin
        access  = req.psel & req.penable & setupSeen;
        aligned = (req.paddr[1:0] == 2'b00);
        isImem  = aligned && (req.paddr[11:10] == busPkg::imemBase[11:10]);
        isDmem  = aligned && (req.paddr[11:10] == busPkg::dmemBase[11:10]);
        isReg   = aligned && (req.paddr[11:10] == busPkg::regBase[11:10])
                  && (req.paddr[9:7] == 3'b000);  // 32 register slots
        isStep  = (req.paddr[11:10] == busPkg::ctrlBase[11:10]) && (req.paddr[9:0] == busPkg::stepOff);
        isPc    = (req.paddr[11:10] == busPkg::ctrlBase[11:10]) && (req.paddr[9:0] == busPkg::pcOff);
        // Only a stepOff read is legal while running
        err     = access && (!(isImem || isDmem || isReg || isStep || isPc)
                  || (busy && !(isStep && !req.pwrite)));
        wrOk    = access & req.pwrite & ~err;
    end

    always_comb begin
        rdMux = '0;
        if (isImem) rdMux = imemData;
        if (isDmem) rdMux = dmemData;
        if (isReg)  rdMux = regData;
        if (isStep) rdMux = {16'b0, stepsLeft};
        if (isPc)   rdMux = pc;
    end

    assign rsp.prdata  = (access && !req.pwrite && !err) ? rdMux : '0;
    assign rsp.pready  = access;  // No wait states
    assign rsp.pslverr = err;

    assign hostRegIdx   = req.paddr[6:2];
    assign hostDmemAddr = req.paddr[9:2];

    assign imemReq.we    = wrOk & isImem;       // Host only
    assign imemReq.addr  = req.paddr[9:2];      // Also host read address
    assign imemReq.wdata = req.pwdata;

    always_comb begin
        if (busy) begin
            dmemReq = coreStore;  // Core owns the port while running
        end else begin
            dmemReq.we    = wrOk & isDmem;
            dmemReq.addr  = hostDmemAddr;
            dmemReq.wdata = req.pwdata;
        end
    end

    assign stepLoad  = wrOk & isStep;
    assign stepValue = req.pwdata[15:0];
    assign pcLoad    = wrOk & isPc;
    assign pcValue   = req.pwdata;

endmodule

// ==== rtl/memoryArray.sv ====
`timescale 1ns/100ps

module memoryArray #(
    parameter type Payload = logic [31:0],  // Word or byte storage
    parameter int  depth   = 256
) (
    input  logic           clk,
    input  busPkg::memReqT wreq,
    input  logic [7:0]     raddr,
    output Payload         rdata
);

    Payload mem [depth];

    always_ff @(posedge clk) begin
        if (wreq.we) begin
            mem[wreq.addr] <= Payload'(wreq.wdata);  // Byte array keeps low bits
        end
    end

    assign rdata = mem[raddr];  // Combinational read

endmodule

// ==== rtl/immediateGen.sv ====
`timescale 1ns/100ps

module immediateGen (
    input  logic [riscvPkg::xlen-1:0] instr,
    input  riscvPkg::immSelT          immSel,
    output logic [riscvPkg::xlen-1:0] immValue
);

    always_comb begin
        case (immSel)
            riscvPkg::immI: immValue = {{20{instr[31]}}, instr[31:20]};
            riscvPkg::immS: immValue = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            riscvPkg::immB: begin
                immValue = {{19{instr[31]}}, instr[31], instr[7],
                            instr[30:25], instr[11:8], 1'b0};  // Halfword offset
            end
            riscvPkg::immU: immValue = {instr[31:12], 12'b0};  // Upper 20 bits
            riscvPkg::immJ: begin
                immValue = {{11{instr[31]}}, instr[31], instr[19:12],
                            instr[20], instr[30:21], 1'b0};
            end
            default:        immValue = '0;
        endcase
    end

endmodule

// ==== rtl/registerFile.sv ====
`timescale 1ns/100ps

module registerFile (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          we,
    input  logic [riscvPkg::regAddrW-1:0] rs1,
    input  logic [riscvPkg::regAddrW-1:0] rs2,
    input  logic [riscvPkg::regAddrW-1:0] rd,
    input  logic [riscvPkg::regAddrW-1:0] hostIdx,  // Host read port
    input  logic [riscvPkg::xlen-1:0]     wdata,
    output logic [riscvPkg::xlen-1:0]     rdata1,
    output logic [riscvPkg::xlen-1:0]     rdata2,
    output logic [riscvPkg::xlen-1:0]     hostData
);

    logic [riscvPkg::xlen-1:0] regs [31:1];  // No storage for x0

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != '0)) begin
            regs[rd] <= wdata;  // Writes to x0 dropped
        end
    end

    assign rdata1   = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2   = (rs2 == '0) ? '0 : regs[rs2];
    assign hostData = (hostIdx == '0) ? '0 : regs[hostIdx];

endmodule

// ==== rtl/aluUnit.sv ====
`timescale 1ns/100ps

module aluUnit (
    input  logic [riscvPkg::xlen-1:0] opA,
    input  logic [riscvPkg::xlen-1:0] opB,
    input  riscvPkg::aluOpT           aluOp,
    output logic [riscvPkg::xlen-1:0] result,
    output logic                      aluFlag  // High when operands differ
);

    assign aluFlag = (opA != opB);  // Always valid for bne

    always_comb begin
        case (aluOp)
            riscvPkg::aluAdd:   result = opA + opB;
            riscvPkg::aluSll:   result = opA << opB[4:0];  // Shift amount from low 5 bits
            riscvPkg::aluPassB: result = opB;              // lui
            riscvPkg::aluNe:    result = {{(riscvPkg::xlen-1){1'b0}}, aluFlag};
            default:            result = '0;
        endcase
    end

endmodule

// ==== rtl/controlUnit.sv ====
`timescale 1ns/100ps

module controlUnit (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [riscvPkg::xlen-1:0]  instr,
    input  logic                       aluFlag,    // Operands differ
    input  logic [riscvPkg::xlen-1:0]  aluResult,
    input  logic [riscvPkg::xlen-1:0]  immValue,
    input  logic                       stepLoad,   // Host budget write
    input  logic [15:0]                stepValue,
    input  logic                       pcLoad,     // Host PC write, halted only
    input  logic [riscvPkg::xlen-1:0]  pcValue,
    output riscvPkg::ctrlWordT         ctrl,
    output logic [riscvPkg::xlen-1:0]  pc,
    output logic [riscvPkg::xlen-1:0]  pcPlus4,
    output logic                       busy,
    output logic [15:0]                stepsLeft
);

    riscvPkg::opcodeT            opcode;
    logic [2:0]                  funct3;
    riscvPkg::ctrlWordT          dec;      // Raw decode before busy gating
    logic [riscvPkg::xlen-1:0]   pcNext;

    assign opcode  = riscvPkg::opcodeT'(instr[6:0]);
    assign funct3  = instr[14:12];
    assign pcPlus4 = pc + 32'd4;
    assign busy    = (stepsLeft != 16'd0);  // Runs until budget is spent

    always_comb begin
        dec = '0;  // Unknown encodings fall through as nop
        case (opcode)
            riscvPkg::opReg: begin
                dec.regWrite = (funct3 == riscvPkg::f3Add) || (funct3 == riscvPkg::f3Sll);
                dec.aluOp    = (funct3 == riscvPkg::f3Sll) ? riscvPkg::aluSll : riscvPkg::aluAdd;
            end
            riscvPkg::opImm: begin
                dec.regWrite  = (funct3 == riscvPkg::f3Add) || (funct3 == riscvPkg::f3Sll);
                dec.aluOp     = (funct3 == riscvPkg::f3Sll) ? riscvPkg::aluSll : riscvPkg::aluAdd;
                dec.aluSrcImm = 1'b1;
                dec.immSel    = riscvPkg::immI;
            end
            riscvPkg::opLoad: begin
                dec.regWrite  = (funct3 == riscvPkg::f3Lbu);  // Only lbu supported
                dec.aluSrcImm = 1'b1;                          // Address is rs1 + imm
                dec.immSel    = riscvPkg::immI;
                dec.resultSel = riscvPkg::resMem;
            end
            riscvPkg::opStore: begin
                dec.memWrite  = (funct3 == riscvPkg::f3Sb);
                dec.aluSrcImm = 1'b1;
                dec.immSel    = riscvPkg::immS;
            end
            riscvPkg::opBranch: begin
                dec.branch = (funct3 == riscvPkg::f3Bne);
                dec.aluOp  = riscvPkg::aluNe;  // Compare rs1 against rs2
                dec.immSel = riscvPkg::immB;
            end
            riscvPkg::opLui: begin
                dec.regWrite  = 1'b1;
                dec.aluOp     = riscvPkg::aluPassB;
                dec.aluSrcImm = 1'b1;
                dec.immSel    = riscvPkg::immU;
            end
            riscvPkg::opAuipc: begin
                dec.regWrite  = 1'b1;
                dec.aluSrcPc  = 1'b1;  // PC + upper immediate
                dec.aluSrcImm = 1'b1;
                dec.immSel    = riscvPkg::immU;
            end
            riscvPkg::opJal: begin
                dec.regWrite  = 1'b1;
                dec.jump      = 1'b1;
                dec.immSel    = riscvPkg::immJ;
                dec.resultSel = riscvPkg::resPcPlus4;  // Link address
            end
            riscvPkg::opJalr: begin
                dec.regWrite  = (funct3 == riscvPkg::f3Jalr);
                dec.jumpReg   = (funct3 == riscvPkg::f3Jalr);
                dec.aluSrcImm = 1'b1;
                dec.immSel    = riscvPkg::immI;
                dec.resultSel = riscvPkg::resPcPlus4;
            end
            default: dec = '0;
        endcase
    end

    always_comb begin
        ctrl          = dec;
        ctrl.regWrite = dec.regWrite & busy;  // Halted core commits nothing
        ctrl.memWrite = dec.memWrite & busy;
    end

    always_comb begin
        if (dec.jumpReg) begin
            pcNext = {aluResult[riscvPkg::xlen-1:1], 1'b0};  // jalr clears bit 0
        end else if (dec.jump || (dec.branch && aluFlag)) begin
            pcNext = pc + immValue;
        end else begin
            pcNext = pcPlus4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc        <= '0;
            stepsLeft <= '0;
        end else begin
            if (busy) begin
                pc <= pcNext;  // One retire per edge
            end else if (pcLoad) begin
                pc <= pcValue;
            end
            if (stepLoad) begin
                stepsLeft <= stepValue;
            end else if (busy) begin
                stepsLeft <= stepsLeft - 16'd1;
            end
        end
    end

endmodule

// ==== rtl/busPkg.sv ====
package busPkg;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [11:0] paddr;
        logic [31:0] pwdata;
    } apbReqT;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apbRspT;

    // Region bases, decoded on paddr[11:10]
    localparam logic [11:0] imemBase = 12'h000;
    localparam logic [11:0] dmemBase = 12'h400;  // One byte per word slot
    localparam logic [11:0] regBase  = 12'h800;
    localparam logic [11:0] ctrlBase = 12'hC00;

    localparam logic [9:0] stepOff = 10'h000;  // Budget write, remaining count read
    localparam logic [9:0] pcOff   = 10'h004;

    typedef struct packed {
        logic        we;
        logic [7:0]  addr;
        logic [31:0] wdata;
    } memReqT;

endpackage

// ==== rtl/riscvPkg.sv ====
package riscvPkg;

    localparam int xlen      = 32;   // Data path width
    localparam int regAddrW  = 5;    // Register index width
    localparam int imemDepth = 256;  // Instruction words
    localparam int dmemDepth = 256;  // Data bytes

    // funct3 codes for the supported instructions
    localparam logic [2:0] f3Add  = 3'b000;
    localparam logic [2:0] f3Sll  = 3'b001;
    localparam logic [2:0] f3Lbu  = 3'b100;
    localparam logic [2:0] f3Sb   = 3'b000;
    localparam logic [2:0] f3Bne  = 3'b001;
    localparam logic [2:0] f3Jalr = 3'b000;

    typedef enum logic [6:0] {
        opReg    = 7'b0110011,  // add, sll
        opImm    = 7'b0010011,  // addi, slli
        opLoad   = 7'b0000011,  // lbu
        opStore  = 7'b0100011,  // sb
        opBranch = 7'b1100011,  // bne
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111
    } opcodeT;

    typedef enum logic [1:0] {aluAdd, aluSll, aluPassB, aluNe} aluOpT;

    typedef enum logic [2:0] {immI, immS, immB, immU, immJ} immSelT;

    typedef enum logic [1:0] {resAlu, resMem, resPcPlus4} resultSelT;  // Register write source

    typedef struct packed {
        logic      regWrite;
        aluOpT     aluOp;
        logic      aluSrcImm;  // Operand B is the immediate
        logic      aluSrcPc;   // Operand A is the PC
        immSelT    immSel;
        logic      memWrite;
        resultSelT resultSel;
        logic      branch;     // bne
        logic      jump;       // jal
        logic      jumpReg;    // jalr
    } ctrlWordT;

endpackage
